//--- verilog/llc_addr_pkg.sv
//**************************************************************************
// line address layout for the LLC, tag bits are whatever lies above the set
// the line address width is fixed for the whole design
//**************************************************************************

package llc_addr_pkg;

    // line address, byte offset already stripped
    localparam int LINE_ADDR_BITS = 26;

    // set index in the low bits
    localparam int LLC_SET_BITS = 10;

    localparam int LLC_TAG_BITS = LINE_ADDR_BITS - LLC_SET_BITS;

    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

    typedef logic [LLC_SET_BITS-1:0] llc_set_t;

    typedef logic [LLC_TAG_BITS-1:0] llc_tag_t;

endpackage

//--- verilog/llc_msg_pkg.sv
//**************************************************************************
// source channel numbering, lower index wins arbitration
//**************************************************************************

package llc_msg_pkg;

    localparam int NUM_CHANNELS = 3;

    // channel indices, also the priority order
    localparam int CH_RSP = 0;
    localparam int CH_REQ = 1;
    localparam int CH_DMA = 2;

    // kind of an output item, carries the channel index
    typedef logic [1:0] llc_kind_t;

    // intake handshake states
    typedef enum logic [1:0] {
        IDLE,
        HELD,
        RELEASE
    } intake_state_t;

endpackage

//--- verilog/llc_channel_intake.sv
//**************************************************************************
// four-phase source port holding one line address at a time
// in_ack is raised only after the arbiter has granted the held item
//**************************************************************************
`timescale 1ns/1ps

module llc_channel_intake (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_req,
    input  llc_addr_pkg::line_addr_t in_addr,
    output logic                     in_ack,
    input  logic                     grant,
    output logic                     pending,
    output llc_addr_pkg::line_addr_t held_addr
);

    import llc_msg_pkg::*;

    intake_state_t state;

    assign pending = (state == HELD);
    assign in_ack  = (state == RELEASE);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (in_req) begin
                        state <= HELD;
                    end
                end
                HELD: begin
                    // wait for the arbiter to move it into the queue
                    if (grant) begin
                        state <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!in_req) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // address capture on entry to HELD
    always_ff @(posedge clk) begin
        if (state == IDLE && in_req) begin
            held_addr <= in_addr;
        end
    end

    // arbiter must only pick an intake that is pending
    assert property (@(posedge clk) disable iff (!rst)
        grant |-> state == HELD);

    // source keeps the address steady once it has raised req
    assert property (@(posedge clk) disable iff (!rst)
        (state == IDLE && in_req) |=> (!in_req || $stable(in_addr)));

endmodule

//--- verilog/llc_input_arbiter.sv
//**************************************************************************
// fixed priority rsp over req over dma with req and dma held back in a stall
// purely combinational and grants only while the decode queue has room
//**************************************************************************
`timescale 1ns/1ps

module llc_input_arbiter (
    input  logic [llc_msg_pkg::NUM_CHANNELS-1:0] pending,
    input  llc_addr_pkg::line_addr_t             held_addr [llc_msg_pkg::NUM_CHANNELS],
    input  logic                                 req_stall,
    input  llc_addr_pkg::line_addr_t             stalled_addr,
    input  logic                                 full,
    output logic [llc_msg_pkg::NUM_CHANNELS-1:0] grant,
    output logic                                 push,
    output logic                                 push_hit,
    output llc_msg_pkg::llc_kind_t               push_kind,
    output llc_addr_pkg::line_addr_t             push_addr
);

    import llc_msg_pkg::*;

    logic [NUM_CHANNELS-1:0] blocked;
    logic [NUM_CHANNELS-1:0] eligible;

    // only responses get through while a request is stalled
    always_comb begin
        blocked = '0;
        blocked[CH_REQ] = req_stall;
        blocked[CH_DMA] = req_stall;
    end

    assign eligible = full ? '0 : (pending & ~blocked);

    // lowest eligible index wins
    always_comb begin
        logic found;
        found = 1'b0;
        grant = '0;
        push_kind = llc_kind_t'(CH_RSP);
        push_addr = held_addr[CH_RSP];
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (eligible[i] && !found) begin
                found = 1'b1;
                grant[i] = 1'b1;
                push_kind = llc_kind_t'(i);
                push_addr = held_addr[i];
            end
        end
    end

    assign push = |grant;

    // a response to the stalled line lets the stall be cleared downstream
    assign push_hit = grant[CH_RSP] && req_stall && (held_addr[CH_RSP] == stalled_addr);

endmodule

//--- verilog/llc_decode_queue.sv
//**************************************************************************
// in-order FIFO of granted items, QUEUE_DEPTH must be a power of two >= 2
//**************************************************************************
`timescale 1ns/1ps

module llc_decode_queue #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  llc_msg_pkg::llc_kind_t   push_kind,
    input  llc_addr_pkg::line_addr_t push_addr,
    input  logic                     push_hit,
    input  logic                     pop,
    output logic                     full,
    output logic                     empty,
    output llc_msg_pkg::llc_kind_t   head_kind,
    output llc_addr_pkg::line_addr_t head_addr,
    output logic                     head_hit
);

    import llc_addr_pkg::*;
    import llc_msg_pkg::*;

    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
    localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    llc_kind_t  kind_mem [QUEUE_DEPTH];
    line_addr_t addr_mem [QUEUE_DEPTH];
    logic       hit_mem  [QUEUE_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    assign full  = (count == CNT_BITS'(QUEUE_DEPTH));
    assign empty = (count == '0);

    assign head_kind = kind_mem[rd_ptr];
    assign head_addr = addr_mem[rd_ptr];
    assign head_hit  = hit_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            kind_mem[wr_ptr] <= push_kind;
            addr_mem[wr_ptr] <= push_addr;
            hit_mem[wr_ptr]  <= push_hit;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst) push |-> !full);

    assert property (@(posedge clk) disable iff (!rst) pop |-> !empty);

endmodule

//--- verilog/llc_line_splitter.sv
//**************************************************************************
// pops one item at a time, fields hold from out_req rise until out_ack
// next item is presented only after out_ack has returned low
//**************************************************************************
`timescale 1ns/1ps

module llc_line_splitter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     empty,
    input  llc_msg_pkg::llc_kind_t   head_kind,
    input  llc_addr_pkg::line_addr_t head_addr,
    input  logic                     head_hit,
    output logic                     pop,
    output logic                     out_req,
    input  logic                     out_ack,
    output llc_msg_pkg::llc_kind_t   out_kind,
    output llc_addr_pkg::llc_tag_t   out_tag,
    output llc_addr_pkg::llc_set_t   out_set,
    output logic                     out_clr_req_stall
);

    import llc_addr_pkg::*;

    typedef enum logic [1:0] {
        SPLIT_IDLE,
        SPLIT_REQ,
        SPLIT_DRAIN
    } split_state_t;

    split_state_t state;

    assign pop     = (state == SPLIT_IDLE) && !empty;
    assign out_req = (state == SPLIT_REQ);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= SPLIT_IDLE;
        end else begin
            case (state)
                SPLIT_IDLE: begin
                    if (!empty) begin
                        state <= SPLIT_REQ;
                    end
                end
                SPLIT_REQ: begin
                    if (out_ack) begin
                        state <= SPLIT_DRAIN;
                    end
                end
                SPLIT_DRAIN: begin
                    // sink must finish its half of the handshake
                    if (!out_ack) begin
                        state <= SPLIT_IDLE;
                    end
                end
                default: begin
                    state <= SPLIT_IDLE;
                end
            endcase
        end
    end

    // tag is everything above the set index
    always_ff @(posedge clk) begin
        if (pop) begin
            out_kind          <= head_kind;
            out_tag           <= head_addr[LINE_ADDR_BITS-1:LLC_SET_BITS];
            out_set           <= head_addr[LLC_SET_BITS-1:0];
            out_clr_req_stall <= head_hit;
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        out_req |=> (!out_req || $stable({out_kind, out_tag, out_set, out_clr_req_stall})));

endmodule

//--- verilog/llc_input_decoder.sv
//**************************************************************************
// LLC input stage, three four-phase source ports into one output port
// latency varies with back-pressure, out_req marks each item
//**************************************************************************
`timescale 1ns/1ps

module llc_input_decoder #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [llc_msg_pkg::NUM_CHANNELS-1:0] in_req,
    output logic [llc_msg_pkg::NUM_CHANNELS-1:0] in_ack,
    input  llc_addr_pkg::line_addr_t             in_addr [llc_msg_pkg::NUM_CHANNELS],
    input  logic                                 req_stall,
    input  llc_addr_pkg::line_addr_t             stalled_addr,
    output logic                                 out_req,
    input  logic                                 out_ack,
    output llc_msg_pkg::llc_kind_t               out_kind,
    output llc_addr_pkg::llc_tag_t               out_tag,
    output llc_addr_pkg::llc_set_t               out_set,
    output logic                                 out_clr_req_stall
);

    import llc_addr_pkg::*;
    import llc_msg_pkg::*;

    logic [NUM_CHANNELS-1:0] pending;
    logic [NUM_CHANNELS-1:0] grant;
    line_addr_t              held_addr [NUM_CHANNELS];

    logic       push;
    logic       push_hit;
    llc_kind_t  push_kind;
    line_addr_t push_addr;

    logic       full;
    logic       empty;
    logic       pop;
    llc_kind_t  head_kind;
    line_addr_t head_addr;
    logic       head_hit;

    // one intake per source channel
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_intake
        llc_channel_intake u_intake (
            .clk       (clk),
            .rst       (rst),
            .in_req    (in_req[ch]),
            .in_addr   (in_addr[ch]),
            .in_ack    (in_ack[ch]),
            .grant     (grant[ch]),
            .pending   (pending[ch]),
            .held_addr (held_addr[ch])
        );
    end

    llc_input_arbiter u_arbiter (
        .pending      (pending),
        .held_addr    (held_addr),
        .req_stall    (req_stall),
        .stalled_addr (stalled_addr),
        .full         (full),
        .grant        (grant),
        .push         (push),
        .push_hit     (push_hit),
        .push_kind    (push_kind),
        .push_addr    (push_addr)
    );

    llc_decode_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_kind (push_kind),
        .push_addr (push_addr),
        .push_hit  (push_hit),
        .pop       (pop),
        .full      (full),
        .empty     (empty),
        .head_kind (head_kind),
        .head_addr (head_addr),
        .head_hit  (head_hit)
    );

    llc_line_splitter u_splitter (
        .clk               (clk),
        .rst               (rst),
        .empty             (empty),
        .head_kind         (head_kind),
        .head_addr         (head_addr),
        .head_hit          (head_hit),
        .pop               (pop),
        .out_req           (out_req),
        .out_ack           (out_ack),
        .out_kind          (out_kind),
        .out_tag           (out_tag),
        .out_set           (out_set),
        .out_clr_req_stall (out_clr_req_stall)
    );

endmodule

//--- tests/llc_tb_model.svh
//**************************************************************************
// expected items per source channel, each entry is {stall hit, line address}
// meant to be included inside the testbench module
//**************************************************************************
`ifndef LLC_TB_MODEL_SVH
`define LLC_TB_MODEL_SVH

logic [26:0] exp_rsp_q [$];
logic [26:0] exp_req_q [$];
logic [26:0] exp_dma_q [$];

// tag is the upper 16 bits of the line, set the lower 10
function automatic logic [15:0] tag_of(input logic [25:0] addr);
    return addr[25:10];
endfunction

function automatic logic [9:0] set_of(input logic [25:0] addr);
    return addr[9:0];
endfunction

// only a response to the stalled line while the stall is up
function automatic logic stall_hit_rule(input logic [1:0] ch, input logic [25:0] addr,
                                        input logic stall, input logic [25:0] stalled);
    return (ch == 2'd0) && stall && (addr == stalled);
endfunction

task automatic expect_item(input logic [1:0] ch, input logic [25:0] addr, input logic hit);
    case (ch)
        2'd0: exp_rsp_q.push_back({hit, addr});
        2'd1: exp_req_q.push_back({hit, addr});
        default: exp_dma_q.push_back({hit, addr});
    endcase
endtask

task automatic take_expected(input logic [1:0] kind, output logic found,
                             output logic [26:0] entry);
    found = 1'b0;
    entry = '0;
    if (kind == 2'd0 && exp_rsp_q.size() > 0) begin
        entry = exp_rsp_q.pop_front();
        found = 1'b1;
    end else if (kind == 2'd1 && exp_req_q.size() > 0) begin
        entry = exp_req_q.pop_front();
        found = 1'b1;
    end else if (kind == 2'd2 && exp_dma_q.size() > 0) begin
        entry = exp_dma_q.pop_front();
        found = 1'b1;
    end
endtask

function automatic int expected_left();
    return exp_rsp_q.size() + exp_req_q.size() + exp_dma_q.size();
endfunction

`endif

//--- tests/tb_llc_input_decoder.sv
//**************************************************************************
// random traffic on all three sources, outputs checked against per-channel
// queues, needs a simulator with timing support, waits give up at 200 cycles
//**************************************************************************
`timescale 1ns/1ps

module tb_llc_input_decoder;

    import llc_addr_pkg::*;
    import llc_msg_pkg::*;

    localparam int TIMEOUT = 200;

    logic                    clk;
    logic                    rst;
    logic [NUM_CHANNELS-1:0] in_req;
    logic [NUM_CHANNELS-1:0] in_ack;
    line_addr_t              in_addr [NUM_CHANNELS];
    logic                    req_stall;
    line_addr_t              stalled_addr;
    logic                    out_req;
    logic                    out_ack;
    llc_kind_t               out_kind;
    llc_tag_t                out_tag;
    llc_set_t                out_set;
    logic                    out_clr_req_stall;

    string test_name;
    int    test_errors;
    int    error_count;
    int    tests_run;
    int    tests_failed;
    int    sink_state;
    int    sink_delay;
    int    sink_wait;
    int    sink_min;
    int    sink_max;

    `include "llc_tb_model.svh"

    llc_input_decoder #(
        .QUEUE_DEPTH (2)
    ) UUT (
        .clk               (clk),
        .rst               (rst),
        .in_req            (in_req),
        .in_ack            (in_ack),
        .in_addr           (in_addr),
        .req_stall         (req_stall),
        .stalled_addr      (stalled_addr),
        .out_req           (out_req),
        .out_ack           (out_ack),
        .out_kind          (out_kind),
        .out_tag           (out_tag),
        .out_set           (out_set),
        .out_clr_req_stall (out_clr_req_stall)
    );

    always #50 clk = ~clk;

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout in %s: %s", test_name, what);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic wait_ack_level(input logic [1:0] ch, input logic level);
        int t;
        t = 0;
        while (in_ack[ch] !== level) begin
            @(posedge clk);
            #1;
            t++;
            if (t > TIMEOUT) begin
                timeout_fail($sformatf("in_ack of channel %0d never went %0d", ch, level));
            end
        end
    endtask

    // one four-phase source, items to stalled_addr every hit_every items
    task automatic send_items(input logic [1:0] ch, input int count, input int hit_every);
        line_addr_t addr;
        int         gap;
        for (int n = 0; n < count; n++) begin
            addr = line_addr_t'($urandom);
            if (hit_every > 0 && n % hit_every == 0) begin
                addr = stalled_addr;
            end
            in_addr[ch] = addr;
            in_req[ch] = 1'b1;
            expect_item(ch, addr, stall_hit_rule(ch, addr, req_stall, stalled_addr));
            wait_ack_level(ch, 1'b1);
            in_req[ch] = 1'b0;
            wait_ack_level(ch, 1'b0);
            gap = $urandom_range(3, 0);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic wait_drained(input logic rsp_only);
        int t;
        t = 0;
        while (rsp_only ? (exp_rsp_q.size() != 0)
                        : (expected_left() != 0 || sink_state != 0)) begin
            @(posedge clk);
            #1;
            t++;
            if (t > TIMEOUT) begin
                timeout_fail($sformatf("%0d sent items never came out", expected_left()));
            end
        end
    endtask

    task automatic check_output();
        logic        found;
        logic [26:0] entry;
        take_expected(out_kind, found, entry);
        assert (found) else begin
            $display("%s: output of kind %0d with nothing sent on that channel",
                     test_name, out_kind);
            note_error();
        end
        if (found) begin
            assert (out_tag == tag_of(entry[25:0])) else begin
                $display("error %s: out_tag expected %h actual %h",
                         test_name, tag_of(entry[25:0]), out_tag);
                note_error();
            end
            assert (out_set == set_of(entry[25:0])) else begin
                $display("error %s: out_set expected %h actual %h",
                         test_name, set_of(entry[25:0]), out_set);
                note_error();
            end
            assert (out_clr_req_stall == entry[26]) else begin
                $display("error %s: out_clr_req_stall expected %b actual %b",
                         test_name, entry[26], out_clr_req_stall);
                note_error();
            end
        end
        assert (!(req_stall && out_kind != 2'd0)) else begin
            $display("%s: kind %0d item came out while req_stall was high",
                     test_name, out_kind);
            note_error();
        end
    endtask

    // output sink, acks each item after a random number of cycles
    always begin
        @(posedge clk);
        #1;
        if (rst) begin
            case (sink_state)
                0: begin
                    if (out_req) begin
                        check_output();
                        sink_delay = $urandom_range(sink_max, sink_min);
                        sink_wait = 0;
                        sink_state = (sink_delay == 0) ? 2 : 1;
                        out_ack = (sink_delay == 0);
                    end
                end
                1: begin
                    sink_delay--;
                    if (sink_delay == 0) begin
                        out_ack = 1'b1;
                        sink_state = 2;
                    end
                end
                default: begin
                    sink_wait++;
                    if (!out_req) begin
                        out_ack = 1'b0;
                        sink_state = 0;
                    end else if (sink_wait > TIMEOUT) begin
                        timeout_fail("out_req stayed high after out_ack");
                    end
                end
            endcase
        end
    end

    initial begin
        void'($urandom(15066));
        clk = 1'b0;
        rst = 1'b0;
        in_req = '0;
        in_addr = '{default: '0};
        req_stall = 1'b0;
        stalled_addr = '0;
        out_ack = 1'b0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        sink_state = 0;
        sink_min = 0;
        sink_max = 5;

        // reset held for 8 cycles, then a few idle cycles
        begin_test("reset_state");
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            #1;
            if (i == 7) begin
                rst = 1'b1;
            end
            assert (in_ack === '0 && out_req === 1'b0) else begin
                $display("error %s: in_ack expected 000 actual %b, out_req expected 0 actual %b",
                         test_name, in_ack, out_req);
                note_error();
            end
        end
        end_test();

        // responses to stalled_addr with the stall low must keep the flag low
        begin_test("split_order");
        stalled_addr = line_addr_t'($urandom);
        fork
            send_items(2'd0, 8, 3);
            send_items(2'd1, 8, 0);
            send_items(2'd2, 8, 0);
        join
        wait_drained(1'b0);
        end_test();

        begin_test("back_pressure");
        sink_min = 6;
        sink_max = 12;
        fork
            send_items(2'd0, 4, 0);
            send_items(2'd1, 4, 0);
            send_items(2'd2, 4, 0);
        join
        wait_drained(1'b0);
        sink_min = 0;
        sink_max = 5;
        end_test();

        begin_test("stall_block");
        req_stall = 1'b1;
        fork
            send_items(2'd1, 1, 0);
            send_items(2'd2, 1, 0);
            begin
                send_items(2'd0, 4, 0);
                wait_drained(1'b1);
                assert (exp_req_q.size() == 1 && exp_dma_q.size() == 1) else begin
                    $display("error %s: held items expected 2 actual %0d",
                             test_name, exp_req_q.size() + exp_dma_q.size());
                    note_error();
                end
                req_stall = 1'b0;
            end
        join
        wait_drained(1'b0);
        end_test();

        begin_test("stall_hit");
        stalled_addr = line_addr_t'($urandom);
        req_stall = 1'b1;
        send_items(2'd0, 8, 2);
        wait_drained(1'b0);
        req_stall = 1'b0;
        end_test();

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- llc_input_decoder.f
+incdir+tests
verilog/llc_addr_pkg.sv
verilog/llc_msg_pkg.sv
verilog/llc_channel_intake.sv
verilog/llc_input_arbiter.sv
verilog/llc_decode_queue.sv
verilog/llc_line_splitter.sv
verilog/llc_input_decoder.sv
tests/tb_llc_input_decoder.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_llc_input_decoder
FILELIST  ?= llc_input_decoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, fails unless the log holds the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
